// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mouse_core
FLIST     ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= all tests passed

SRCS := $(shell cat $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== files.f ====
mouse_pkg.sv
mouse_decoder.sv
mouse_alu.sv
mouse_ctl.sv
mouse_core.sv
tb_mouse_core.sv

// ==== mouse_alu.sv ====
// one 33 bit adder shared by address, arithmetic and compare; shift amount is op_b[4:0]
`timescale 1ns/1ps

module mouse_alu import mouse_pkg::*; (
    input  logic [1:0]      mode,
    input  logic [2:0]      fn3,
    input  logic            alt,
    input  logic [XLEN-1:0] op_a,
    input  logic [XLEN-1:0] op_b,
    output logic [XLEN-1:0] sum,
    output logic [XLEN-1:0] result,
    output logic            taken
);

    logic                   add_sub;  // invert op_b, carry in
    logic                   add_uns;  // zero extend to 33 bits
    logic        [XLEN:0]   add_op1;
    logic        [XLEN:0]   add_op2;
    logic        [XLEN:0]   add_sum;
    logic                   add_sgn;  // true sign, never overflows
    logic                   add_zro;
    logic        [XLEN-1:0] shf_tmp;
    logic signed [XLEN:0]   shf_ext;
    logic signed [XLEN:0]   shf_res;
    logic        [XLEN-1:0] shf_val;

    function automatic logic [XLEN-1:0] bitrev(input logic [XLEN-1:0] val);
        for (int i = 0; i < XLEN; i++) begin
            bitrev[i] = val[XLEN-1-i];
        end
    endfunction

    ////////////////////////////////////////
    // adder
    ////////////////////////////////////////

    always_comb begin
        case (mode)
            ALU_ARITH: begin
                add_sub = (fn3 == F3_ADD) ? alt : 1'b1;  // slt/sltu always subtract
                add_uns = (fn3 == F3_SLTU);
            end
            ALU_CMP: begin
                add_sub = 1'b1;
                add_uns = (fn3 == F3_BLTU) || (fn3 == F3_BGEU);
            end
            default: begin
                add_sub = 1'b0;
                add_uns = 1'b1;
            end
        endcase
    end

    assign add_op1 = {~add_uns & op_a[XLEN-1], op_a};
    assign add_op2 = {~add_uns & op_b[XLEN-1], op_b} ^ {(XLEN+1){add_sub}};
    assign add_sum = add_op1 + add_op2 + {{XLEN{1'b0}}, add_sub};
    assign add_sgn = add_sum[XLEN];
    assign add_zro = (add_sum[XLEN-1:0] == '0);
    assign sum     = add_sum[XLEN-1:0];

    ////////////////////////////////////////
    // barrel shifter, left = reversed right
    ////////////////////////////////////////

    assign shf_tmp = (fn3 == F3_SL) ? bitrev(op_a) : op_a;
    assign shf_ext = {alt & shf_tmp[XLEN-1], shf_tmp};  // sra fill
    assign shf_res = shf_ext >>> op_b[XLOG-1:0];
    assign shf_val = shf_res[XLEN-1:0];

    // result by funct3
    always_comb begin
        case (fn3)
            F3_ADD:          result = sum;
            F3_SLT, F3_SLTU: result = {{(XLEN-1){1'b0}}, add_sgn};
            F3_XOR:          result = op_a ^ op_b;
            F3_OR:           result = op_a | op_b;
            F3_AND:          result = op_a & op_b;
            F3_SR:           result = shf_val;
            F3_SL:           result = bitrev(shf_val);
            default:         result = sum;
        endcase
    end

    // branch condition from zero and sign of the difference
    always_comb begin
        case (fn3)
            F3_BEQ:  taken =  add_zro;
            F3_BNE:  taken = ~add_zro;
            F3_BLT,
            F3_BLTU: taken =  add_sgn;
            F3_BGE,
            F3_BGEU: taken = ~add_sgn;
            default: taken = 1'b0;
        endcase
    end

endmodule

// ==== mouse_core.sv ====
// multi-cycle rv32i core; gprs live in bus memory at GPR_BASE, bus needs one cycle read latency
`timescale 1ns/1ps

module mouse_core import mouse_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    output logic            tcb_vld,
    output logic            tcb_ren,
    output logic            tcb_wen,
    output logic            tcb_xen,
    output logic [XLEN-1:0] tcb_adr,
    output logic [XLEN-1:0] tcb_wdt,
    input  logic [XLEN-1:0] tcb_rdt,
    input  logic            tcb_rdy
);

    instr_u          instr;
    logic [4:0]      opc;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [2:0]      fn3;
    logic            alt;       // sub/sra select
    logic [XLEN-1:0] imm;
    logic [1:0]      alu_mode;
    logic [XLEN-1:0] alu_a;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_sum;
    logic [XLEN-1:0] alu_result;
    logic            alu_taken;

    mouse_ctl u_ctl (
        .clk, .rst,
        .tcb_vld, .tcb_ren, .tcb_wen, .tcb_xen, .tcb_adr, .tcb_wdt,
        .tcb_rdt, .tcb_rdy,
        .instr,
        .opc, .rd, .rs1, .rs2, .fn3, .imm,
        .alu_mode, .alu_a, .alu_b,
        .alu_sum, .alu_result, .alu_taken
    );

    mouse_decoder u_decoder (
        .instr, .opc, .rd, .rs1, .rs2, .fn3, .alt, .imm
    );

    // fn3 and alt go straight from decode
    mouse_alu u_alu (
        .mode (alu_mode), .fn3, .alt, .op_a (alu_a), .op_b (alu_b),
        .sum (alu_sum), .result (alu_result), .taken (alu_taken)
    );

endmodule

// ==== mouse_ctl.sv ====
// read data must appear on tcb_rdt the cycle after its transfer and hold until the next one
`timescale 1ns/1ps

module mouse_ctl import mouse_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    // system bus
    output logic            tcb_vld,
    output logic            tcb_ren,
    output logic            tcb_wen,
    output logic            tcb_xen,
    output logic [XLEN-1:0] tcb_adr,
    output logic [XLEN-1:0] tcb_wdt,
    input  logic [XLEN-1:0] tcb_rdt,
    input  logic            tcb_rdy,
    // decoder
    output instr_u          instr,
    input  logic [4:0]      opc,
    input  logic [4:0]      rd,
    input  logic [4:0]      rs1,
    input  logic [4:0]      rs2,
    input  logic [2:0]      fn3,
    input  logic [XLEN-1:0] imm,
    // alu
    output logic [1:0]      alu_mode,
    output logic [XLEN-1:0] alu_a,
    output logic [XLEN-1:0] alu_b,
    input  logic [XLEN-1:0] alu_sum,
    input  logic [XLEN-1:0] alu_result,
    input  logic            alu_taken
);

    logic            ctl_run;  // low for one cycle out of reset
    logic [1:0]      ctl_fsm;
    logic [1:0]      ctl_nxt;
    logic            ctl_ena;  // step done
    logic            bus_vld;  // before run gating
    logic            bus_trn;
    logic [XLEN-1:0] pc_reg;
    logic [XLEN-1:0] pc_nxt;
    instr_u          ifu_buf;
    logic [XLEN-1:0] buf_dat;  // rs1 value
    logic            buf_tkn;

    function automatic logic [XLEN-1:0] gpr_adr(input logic [4:0] idx);
        gpr_adr = GPR_BASE + {{(XLEN-7){1'b0}}, idx, 2'b00};
    endfunction

    // fetched word is still on the bus while rs1 is addressed
    always_comb begin
        if (ctl_fsm == ST_RS1) begin
            instr = tcb_rdt;
        end else begin
            instr = ifu_buf;
        end
    end

    ////////////////////////////////////////
    // sequencer, combinational part
    ////////////////////////////////////////

    always_comb begin
        ctl_nxt  = ST_FETCH;
        bus_vld  = 1'b0;
        tcb_ren  = 1'b0;
        tcb_wen  = 1'b0;
        tcb_xen  = 1'b0;
        tcb_adr  = gpr_adr(rd);  // most common target
        tcb_wdt  = alu_sum;
        alu_mode = ALU_ADD;
        alu_a    = pc_reg;
        alu_b    = XLEN'(4);

        case (ctl_fsm)
            ST_FETCH: begin
                ctl_nxt = ST_RS1;
                bus_vld = 1'b1;
                tcb_ren = 1'b1;
                tcb_xen = 1'b1;
                case (opc)  // still the previous instruction
                    OPC_JAL:    alu_b = imm;
                    OPC_JALR: begin
                        alu_a = buf_dat;
                        alu_b = imm;
                    end
                    OPC_BRANCH: alu_b = buf_tkn ? imm : XLEN'(4);
                    default: ;  // pc + 4
                endcase
                tcb_adr = (opc == OPC_JALR) ? {alu_sum[XLEN-1:1], 1'b0} : alu_sum;
            end
            ST_RS1: begin
                bus_vld = 1'b1;
                case (opc)
                    OPC_LUI, OPC_AUIPC, OPC_JAL: begin
                        tcb_wen = |rd;  // x0 write still transfers
                        if (opc == OPC_LUI) begin
                            tcb_wdt = imm;
                        end else if (opc == OPC_AUIPC) begin
                            alu_b = imm;
                        end
                    end
                    OPC_OP_IMM, OPC_JALR: begin
                        ctl_nxt = ST_EXEC;
                        tcb_ren = 1'b1;
                        tcb_adr = gpr_adr(rs1);
                    end
                    OPC_OP, OPC_LOAD, OPC_STORE, OPC_BRANCH: begin
                        ctl_nxt = ST_RS2_MEM;
                        tcb_ren = 1'b1;
                        tcb_adr = gpr_adr(rs1);
                    end
                    default: bus_vld = 1'b0;  // unknown, skip to next fetch
                endcase
            end
            ST_RS2_MEM: begin
                ctl_nxt = ST_EXEC;
                bus_vld = 1'b1;
                tcb_ren = 1'b1;
                if (opc == OPC_LOAD) begin
                    alu_a   = tcb_rdt;  // rs1 live
                    alu_b   = imm;
                    tcb_adr = alu_sum;
                end else begin
                    tcb_adr = gpr_adr(rs2);
                end
            end
            ST_EXEC: begin
                bus_vld = 1'b1;
                tcb_wen = |rd;
                case (opc)
                    OPC_OP_IMM: begin
                        alu_mode = ALU_ARITH;
                        alu_a    = tcb_rdt;  // rs1
                        alu_b    = imm;
                        tcb_wdt  = alu_result;
                    end
                    OPC_OP: begin
                        alu_mode = ALU_ARITH;
                        alu_a    = buf_dat;
                        alu_b    = tcb_rdt;  // rs2
                        tcb_wdt  = alu_result;
                    end
                    OPC_LOAD:   tcb_wdt = tcb_rdt;
                    OPC_STORE: begin
                        tcb_wen = 1'b1;
                        alu_a   = buf_dat;
                        alu_b   = imm;
                        tcb_adr = alu_sum;
                        tcb_wdt = tcb_rdt;  // rs2
                    end
                    OPC_BRANCH: begin
                        bus_vld  = 1'b0;  // idle, evaluate only
                        tcb_wen  = 1'b0;
                        alu_mode = ALU_CMP;
                        alu_a    = buf_dat;
                        alu_b    = tcb_rdt;
                    end
                    default: ;  // jalr link, pc + 4
                endcase
            end
            default: ;
        endcase
    end

    assign pc_nxt  = tcb_adr;
    assign bus_trn = ctl_run & tcb_rdy;
    assign ctl_ena = bus_trn | ~bus_vld;  // idle steps advance at once
    assign tcb_vld = bus_vld & ctl_run;

    ////////////////////////////////////////
    // sequencer, registers
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ctl_run <= 1'b0;
            ctl_fsm <= ST_FETCH;
            pc_reg  <= RESET_PC;
            ifu_buf <= {20'd0, 5'd0, OPC_JAL, 2'b11};  // jal x0, 0
            buf_tkn <= 1'b0;
        end else begin
            ctl_run <= 1'b1;
            if (ctl_ena) begin
                ctl_fsm <= ctl_nxt;
                case (ctl_fsm)
                    ST_FETCH: pc_reg  <= pc_nxt;
                    ST_RS1:   ifu_buf <= tcb_rdt;
                    ST_EXEC:  buf_tkn <= alu_taken;
                    default: ;
                endcase
            end
        end
    end

    // rs1 arrives in rs2/mem step, or in exec for op_imm/jalr
    always_ff @(posedge clk) begin
        if (ctl_ena && (ctl_fsm == ST_RS2_MEM || ctl_fsm == ST_EXEC)) begin
            buf_dat <= tcb_rdt;
        end
    end

endmodule

// ==== mouse_decoder.sv ====
// pure combinational decode; unknown opcodes get the I immediate and alt low
`timescale 1ns/1ps

module mouse_decoder import mouse_pkg::*; (
    input  instr_u            instr,
    output logic [4:0]        opc,
    output logic [4:0]        rd,
    output logic [4:0]        rs1,
    output logic [4:0]        rs2,
    output logic [2:0]        fn3,
    output logic              alt,
    output logic [XLEN-1:0]   imm
);

    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;

    // register fields sit in the same place in every format
    assign opc = instr.r.opcode[6:2];
    assign rd  = instr.r.rd;
    assign rs1 = instr.r.rs1;
    assign rs2 = instr.r.rs2;
    assign fn3 = instr.r.funct3;

    // sign extended immediates
    assign imm_i = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
    assign imm_s = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
    assign imm_b = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                    instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
    assign imm_u = {instr.u.imm_31_12, 12'd0};
    assign imm_j = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                    instr.j.imm_11, instr.j.imm_10_1, 1'b0};

    always_comb begin
        case (opc)
            OPC_STORE:           imm = imm_s;
            OPC_BRANCH:          imm = imm_b;
            OPC_LUI, OPC_AUIPC:  imm = imm_u;
            OPC_JAL:             imm = imm_j;
            default:             imm = imm_i;  // op_imm, load, jalr
        endcase
    end

    // funct7[5] only means sub/sra where it is an opcode bit, not imm
    always_comb begin
        alt = 1'b0;
        if (opc == OPC_OP) begin
            alt = instr.r.funct7[5];
        end else if (opc == OPC_OP_IMM && fn3 == F3_SR) begin
            alt = instr.r.funct7[5];  // srai
        end
    end

endmodule

// ==== mouse_pkg.sv ====
// rv32i subset constants only; the gpr window base must have its low 7 bits clear
package mouse_pkg;

    ////////////////////////////////////////
    // widths and bus map
    ////////////////////////////////////////

    localparam int unsigned XLEN = 32;
    localparam int unsigned XLOG = 5;    // shift amount width

    localparam logic [XLEN-1:0] GPR_BASE = 32'h0000_0f80;  // x0 here, xN at +4*N
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    // opcode field [6:2], low two bits ignored
    localparam logic [4:0] OPC_LOAD   = 5'b00_000;
    localparam logic [4:0] OPC_OP_IMM = 5'b00_100;
    localparam logic [4:0] OPC_AUIPC  = 5'b00_101;
    localparam logic [4:0] OPC_STORE  = 5'b01_000;
    localparam logic [4:0] OPC_OP     = 5'b01_100;
    localparam logic [4:0] OPC_LUI    = 5'b01_101;
    localparam logic [4:0] OPC_BRANCH = 5'b11_000;
    localparam logic [4:0] OPC_JALR   = 5'b11_001;
    localparam logic [4:0] OPC_JAL    = 5'b11_011;

    // funct3, alu ops
    localparam logic [2:0] F3_ADD  = 3'b000;  // sub when funct7[5]
    localparam logic [2:0] F3_SL   = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;  // sra when funct7[5]
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // funct3, branches
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    ////////////////////////////////////////
    // sequencer states and alu modes
    ////////////////////////////////////////

    localparam logic [1:0] ST_FETCH   = 2'd0;  // fetch, also next pc
    localparam logic [1:0] ST_RS1     = 2'd1;  // rs1 read or short write-back
    localparam logic [1:0] ST_RS2_MEM = 2'd2;  // rs2 read or load
    localparam logic [1:0] ST_EXEC    = 2'd3;  // write-back, store or branch eval

    localparam logic [1:0] ALU_ADD   = 2'd0;  // plain sum
    localparam logic [1:0] ALU_ARITH = 2'd1;  // result by funct3
    localparam logic [1:0] ALU_CMP   = 2'd2;  // difference for branches

    ////////////////////////////////////////
    // instruction formats
    ////////////////////////////////////////

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_r_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_i_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } instr_s_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } instr_b_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_u_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_j_t;

    // one word, six views
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
        instr_s_t s;
        instr_b_t b;
        instr_u_t u;
        instr_j_t j;
    } instr_u;

endpackage

// ==== program_input.hex ====
# p address word | t test name | w register value | s address value
# all numbers hex, records in write-back order
p 00000000 123450b7
p 00000004 00001117
p 00000008 008001ef
p 0000000c 00bad237
p 00000010 0080006f
p 00000014 00bad237
p 00000018 ff900293
p 0000001c 00c00313
p 00000020 006283b3
p 00000024 40628433
p 00000028 0062a4b3
p 0000002c 0062b533
p 00000030 0f02c593
p 00000034 0062e633
p 00000038 0ff2f693
p 0000003c 01c31713
p 00000040 40475793
p 00000044 00475813
p 00000048 0002a893
p 0000004c 00c2b913
p 00000050 00628463
p 00000054 00629463
p 00000058 fff00a93
p 0000005c 00100a13
p 00000060 00529463
p 00000064 00528463
p 00000068 fff00a93
p 0000006c 00200a13
p 00000070 0062d463
p 00000074 0062c463
p 00000078 fff00a93
p 0000007c 00300a13
p 00000080 00534463
p 00000084 00535463
p 00000088 fff00a93
p 0000008c 00400a13
p 00000090 0062e463
p 00000094 0062f463
p 00000098 fff00a93
p 0000009c 00500a13
p 000000a0 00537463
p 000000a4 00536463
p 000000a8 fff00a93
p 000000ac 00600a13
p 000000b0 40000b13
p 000000b4 008b2423
p 000000b8 008b2b83
p 000000bc 0c900c13
p 000000c0 000c0ce7
p 000000c4 fff00a93
p 000000c8 00700d13
p 000000cc 0000006f
t upper
w 01 12345000
w 02 00001004
w 03 0000000c
t alu
w 05 fffffff9
w 06 0000000c
w 07 00000005
w 08 ffffffed
w 09 00000001
w 0a 00000000
w 0b ffffff09
w 0c fffffffd
w 0d 000000f9
w 0e c0000000
w 0f fc000000
w 10 0c000000
w 11 00000001
w 12 00000000
t branch
w 14 00000001
w 14 00000002
w 14 00000003
w 14 00000004
w 14 00000005
w 14 00000006
t memory
w 16 00000400
s 00000408 ffffffed
w 17 ffffffed
t jalr
w 18 000000c9
w 19 000000c4
w 1a 00000007

// ==== tb_mouse_core.sv ====
// self-checking testbench; memory model has one cycle read latency, 1024 words from address 0
`timescale 1ns/1ps

module tb_mouse_core import mouse_pkg::*; ();

    localparam int unsigned MEM_WORDS = 1024;
    localparam int unsigned MAX_RECS  = 256;
    localparam int unsigned MAX_TESTS = 32;

    logic            clk;
    logic            rst;
    logic            tcb_vld;
    logic            tcb_ren;
    logic            tcb_wen;
    logic            tcb_xen;
    logic [XLEN-1:0] tcb_adr;
    logic [XLEN-1:0] tcb_wdt;
    logic [XLEN-1:0] tcb_rdt;
    logic            tcb_rdy;

    logic [31:0]  mem [0:MEM_WORDS-1];
    logic         is_code [0:MEM_WORDS-1];   // word preloaded as program
    logic [7:0]   rec_kind [0:MAX_RECS-1];   // "w" register, "s" store
    logic [31:0]  rec_key  [0:MAX_RECS-1];
    logic [31:0]  rec_val  [0:MAX_RECS-1];
    int           rec_test [0:MAX_RECS-1];
    reg [127:0]   test_name [0:MAX_TESTS-1];
    logic         test_bad  [0:MAX_TESTS-1];
    int           rec_cnt;
    int           rec_idx;
    int           test_cnt;
    int           ok_cnt;
    int           bad_cnt;
    logic         loaded;
    logic         file_ok;
    logic [31:0]  rnd;
    logic         stall_seen;
    logic [67:0]  bus_prev;
    logic [67:0]  bus_now;

    mouse_core u_mouse_core (
        .clk, .rst,
        .tcb_vld, .tcb_ren, .tcb_wen, .tcb_xen, .tcb_adr, .tcb_wdt,
        .tcb_rdt, .tcb_rdy
    );

    assign bus_now = {tcb_vld, tcb_ren, tcb_wen, tcb_xen, tcb_adr, tcb_wdt};

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    ////////////////////////////////////////
    // data file
    ////////////////////////////////////////

    task automatic read_program(output logic ok);
        int          fd;
        int          n;
        reg [8*96-1:0] line;
        reg [63:0]   tag;
        reg [127:0]  name;
        logic [31:0] a;
        logic [31:0] v;
        fd = $fopen("program_input.hex", "r");
        if (fd == 0) begin
            ok = 1'b0;
        end else begin
            ok = 1'b1;
            while (!$feof(fd)) begin
                line = '0;
                n = $fgets(line, fd);
                tag = '0;
                if (n > 0) n = $sscanf(line, "%s", tag);
                if (n < 1) continue;   // blank line
                if (tag == "p") begin
                    n = $sscanf(line, "%s %h %h", tag, a, v);
                    mem[a[11:2]]     = v;
                    is_code[a[11:2]] = 1'b1;
                end else if (tag == "t") begin
                    n = $sscanf(line, "%s %s", tag, name);
                    test_name[test_cnt] = name;
                    test_bad[test_cnt]  = 1'b0;
                    test_cnt = test_cnt + 1;
                end else if (tag == "w" || tag == "s") begin
                    n = $sscanf(line, "%s %h %h", tag, a, v);
                    rec_kind[rec_cnt] = tag[7:0];
                    rec_key[rec_cnt]  = a;
                    rec_val[rec_cnt]  = v;
                    rec_test[rec_cnt] = test_cnt - 1;
                    rec_cnt = rec_cnt + 1;
                end
            end
            $fclose(fd);
        end
    endtask

    ////////////////////////////////////////
    // checking and reporting
    ////////////////////////////////////////

    task automatic finish_run();
        $display("done: %0d of %0d tests ok, %0d bad", ok_cnt, test_cnt, bad_cnt);
        if (bad_cnt == 0 && ok_cnt == test_cnt) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    endtask

    task automatic check_write(input logic [31:0] adr, input logic [31:0] dat);
        logic [7:0]  kind;
        logic [31:0] key;
        int          t;
        if (adr >= GPR_BASE && adr < GPR_BASE + 32'd128) begin
            kind = "w";
            key  = (adr - GPR_BASE) >> 2;   // register index
        end else begin
            kind = "s";
            key  = adr;
        end
        if (rec_idx >= rec_cnt) begin
            $display("write to %h after the last expected record", adr);
            bad_cnt = bad_cnt + 1;
        end else begin
            t = rec_test[rec_idx];
            assert (kind == rec_kind[rec_idx] && key == rec_key[rec_idx]
                    && dat == rec_val[rec_idx])
            else begin
                $display("error %0s: expected %c %h = %h, actual %c %h = %h",
                         test_name[t], rec_kind[rec_idx], rec_key[rec_idx],
                         rec_val[rec_idx], kind, key, dat);
                test_bad[t] = 1'b1;
            end
            rec_idx = rec_idx + 1;
            // last record of this test
            if (rec_idx == rec_cnt || rec_test[rec_idx] != t) begin
                if (test_bad[t]) begin
                    $display("test %0s failed", test_name[t]);
                    bad_cnt = bad_cnt + 1;
                end else begin
                    $display("test %0s passed", test_name[t]);
                    ok_cnt = ok_cnt + 1;
                end
            end
            if (rec_idx == rec_cnt) finish_run();
        end
    endtask

    ////////////////////////////////////////
    // clock, reset, memory model
    ////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        rst        = 1'b1;
        tcb_rdy    = 1'b0;
        tcb_rdt    = '0;
        rnd        = 32'h527b;
        stall_seen = 1'b0;
        bus_prev   = '0;
        rec_cnt    = 0;
        rec_idx    = 0;
        test_cnt   = 0;
        ok_cnt     = 0;
        bad_cnt    = 0;
        loaded     = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            is_code[i] = 1'b0;
            if (i >= int'(GPR_BASE >> 2)) mem[i] = '0;   // gpr window
            else mem[i] = {16'hbad0, 6'd0, i[9:0]} ^ (i << 20);
        end
        read_program(file_ok);
        if (!file_ok) begin
            $display("cannot open program_input.hex");
            $display("tests failed");
            $finish;
        end else begin
            loaded = 1'b1;
            repeat (2) @(posedge clk);
            rst <= 1'b0;
        end
    end

    always @(posedge clk) begin
        rnd = xorshift(rnd);
        tcb_rdy <= (rnd[1:0] != 2'b00);   // stall one cycle in four
        if (!rst) begin
            if (stall_seen) begin
                assert (bus_now == bus_prev)
                else begin
                    $display("bus outputs changed while the memory stalled the core");
                    bad_cnt = bad_cnt + 1;
                end
            end
            stall_seen = tcb_vld & ~tcb_rdy;
            bus_prev   = bus_now;
            if (tcb_vld && tcb_rdy) begin
                // word bus, jalr targets included
                assert (tcb_adr[1:0] == 2'b00)
                else begin
                    $display("transfer to %h is not word aligned", tcb_adr);
                    bad_cnt = bad_cnt + 1;
                end
                // only reads of program words are fetches
                assert (tcb_xen == (tcb_ren && is_code[tcb_adr[11:2]]))
                else begin
                    $display("fetch flag is %b on the transfer to %h", tcb_xen, tcb_adr);
                    bad_cnt = bad_cnt + 1;
                end
                if (tcb_ren) tcb_rdt <= mem[tcb_adr[11:2]];
                if (tcb_wen) begin
                    mem[tcb_adr[11:2]] = tcb_wdt;
                    check_write(tcb_adr, tcb_wdt);
                end
            end
        end
    end

    // limit scales with the number of expected records
    initial begin
        wait (loaded);
        repeat (rec_cnt * 16 + 100) @(posedge clk);
        $display("watchdog: the core stopped producing write-backs, %0d of %0d seen",
                 rec_idx, rec_cnt);
        $display("tests failed");
        $finish;
    end

endmodule
